// File: axi_cfg_pkg.sv
`default_nettype none

package axi_cfg_pkg;

  // Crossbar size
  localparam int SLV_NUM = 3;
  localparam int MST_NUM = 2;

  // Master-side transaction ID
  localparam int ID_BITS = 4;

  // Master index carried above the ID on the slave side
  localparam int MST_BITS = 2;
  localparam int IDS_BITS = ID_BITS + MST_BITS;

  // Read data
  localparam int DATA_BITS = 32;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_EXOKAY = 2'b01;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// File: axi_types_pkg.sv
`default_nettype none

package axi_types_pkg;

  // Write response payload
  typedef struct packed {
    logic [1:0] resp;
  } b_payload_t;

  // Read response payload, single beat
  typedef struct packed {
    logic [axi_cfg_pkg::DATA_BITS-1:0] data;
    logic [1:0]                        resp;
  } r_payload_t;

  // Slave currently holding the channel
  typedef enum logic [1:0] {
    GRANT_NONE = 2'd0,
    GRANT_S0   = 2'd1,
    GRANT_S1   = 2'd2,
    GRANT_S2   = 2'd3
  } grant_t;

endpackage

`default_nettype wire

// File: resp_arb.sv
`timescale 1ns/1ps
`default_nettype none

module resp_arb #(
  parameter type payload_t = axi_types_pkg::b_payload_t
) (
  input  logic                               clk,
  input  logic                               rstn,
  // Slave side
  input  logic [axi_cfg_pkg::IDS_BITS-1:0]   s_id      [axi_cfg_pkg::SLV_NUM],
  input  payload_t                           s_payload [axi_cfg_pkg::SLV_NUM],
  input  logic [axi_cfg_pkg::SLV_NUM-1:0]    s_valid,
  output logic [axi_cfg_pkg::SLV_NUM-1:0]    s_ready,
  // Master side
  output logic [axi_cfg_pkg::ID_BITS-1:0]    m_id      [axi_cfg_pkg::MST_NUM],
  output payload_t                           m_payload [axi_cfg_pkg::MST_NUM],
  output logic [axi_cfg_pkg::MST_NUM-1:0]    m_valid,
  input  logic [axi_cfg_pkg::MST_NUM-1:0]    m_ready
);

  axi_types_pkg::grant_t grant_q;
  axi_types_pkg::grant_t grant_d;
  axi_types_pkg::grant_t rot_grant;

  logic [axi_cfg_pkg::SLV_NUM-1:0]  sel_oh;
  int unsigned                      sel_idx;
  logic                             sel_valid;
  logic                             sel_ready;
  logic [axi_cfg_pkg::IDS_BITS-1:0] sel_id;
  payload_t                         sel_payload;
  logic [axi_cfg_pkg::MST_BITS-1:0] mst_idx;

  function automatic axi_types_pkg::grant_t to_grant(input int unsigned idx);
    axi_types_pkg::grant_t g;
    case (idx)
      0:       g = axi_types_pkg::GRANT_S0;
      1:       g = axi_types_pkg::GRANT_S1;
      2:       g = axi_types_pkg::GRANT_S2;
      default: g = axi_types_pkg::GRANT_NONE;
    endcase
    return g;
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      grant_q <= axi_types_pkg::GRANT_NONE;
    end else begin
      grant_q <= grant_d;
    end
  end

  // Locked slave, or lowest valid one when free
  always_comb begin : pick
    logic found;
    found  = 1'b0;
    sel_oh = '0;
    case (grant_q)
      axi_types_pkg::GRANT_S0: sel_oh[0] = 1'b1;
      axi_types_pkg::GRANT_S1: sel_oh[1] = 1'b1;
      axi_types_pkg::GRANT_S2: sel_oh[2] = 1'b1;
      default: begin
        for (int i = 0; i < axi_cfg_pkg::SLV_NUM; i++) begin
          if (s_valid[i] && !found) begin
            sel_oh[i] = 1'b1;
            found     = 1'b1;
          end
        end
      end
    endcase
  end

  always_comb begin : slave_mux
    sel_idx     = 0;
    sel_id      = '0;
    sel_payload = '0;
    for (int i = 0; i < axi_cfg_pkg::SLV_NUM; i++) begin
      if (sel_oh[i]) begin
        sel_idx     = i;
        sel_id      = s_id[i];
        sel_payload = s_payload[i];
      end
    end
    sel_valid = |(sel_oh & s_valid);
  end

  assign mst_idx = sel_id[axi_cfg_pkg::IDS_BITS-1 -: axi_cfg_pkg::MST_BITS];

  // Unmapped master codes are sunk here
  always_comb begin : master_decode
    sel_ready = 1'b1;
    for (int i = 0; i < axi_cfg_pkg::MST_NUM; i++) begin
      m_valid[i]   = sel_valid && (int'(mst_idx) == i);
      m_id[i]      = sel_id[axi_cfg_pkg::ID_BITS-1:0];
      m_payload[i] = sel_payload;
      if (int'(mst_idx) == i) begin
        sel_ready = m_ready[i];
      end
    end
  end

  always_comb begin : ready_back
    for (int i = 0; i < axi_cfg_pkg::SLV_NUM; i++) begin
      s_ready[i] = sel_oh[i] && s_valid[i] && sel_ready;
    end
  end

  // First valid slave after the current one, wrapping around
  always_comb begin : rotate
    int unsigned idx;
    rot_grant = axi_types_pkg::GRANT_NONE;
    for (int k = axi_cfg_pkg::SLV_NUM - 1; k >= 1; k--) begin
      idx = (sel_idx + k) % axi_cfg_pkg::SLV_NUM;
      if (s_valid[idx]) begin
        rot_grant = to_grant(idx);
      end
    end
  end

  // Hold on a stall, move on after a transfer
  always_comb begin : next_grant
    grant_d = grant_q;
    if (sel_valid) begin
      if (sel_ready) begin
        grant_d = rot_grant;
      end else begin
        grant_d = to_grant(sel_idx);
      end
    end
  end

endmodule

`default_nettype wire

// File: resp_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module resp_xbar (
  input  logic                                clk,
  input  logic                                rstn,
  // B channel, slave side
  input  logic [axi_cfg_pkg::IDS_BITS-1:0]    b_s_id    [axi_cfg_pkg::SLV_NUM],
  input  logic [1:0]                          b_s_resp  [axi_cfg_pkg::SLV_NUM],
  input  logic [axi_cfg_pkg::SLV_NUM-1:0]     b_s_valid,
  output logic [axi_cfg_pkg::SLV_NUM-1:0]     b_s_ready,
  // B channel, master side
  output logic [axi_cfg_pkg::ID_BITS-1:0]     b_m_id    [axi_cfg_pkg::MST_NUM],
  output logic [1:0]                          b_m_resp  [axi_cfg_pkg::MST_NUM],
  output logic [axi_cfg_pkg::MST_NUM-1:0]     b_m_valid,
  input  logic [axi_cfg_pkg::MST_NUM-1:0]     b_m_ready,
  // R channel, slave side
  input  logic [axi_cfg_pkg::IDS_BITS-1:0]    r_s_id    [axi_cfg_pkg::SLV_NUM],
  input  logic [axi_cfg_pkg::DATA_BITS-1:0]   r_s_data  [axi_cfg_pkg::SLV_NUM],
  input  logic [1:0]                          r_s_resp  [axi_cfg_pkg::SLV_NUM],
  input  logic [axi_cfg_pkg::SLV_NUM-1:0]     r_s_valid,
  output logic [axi_cfg_pkg::SLV_NUM-1:0]     r_s_ready,
  // R channel, master side
  output logic [axi_cfg_pkg::ID_BITS-1:0]     r_m_id    [axi_cfg_pkg::MST_NUM],
  output logic [axi_cfg_pkg::DATA_BITS-1:0]   r_m_data  [axi_cfg_pkg::MST_NUM],
  output logic [1:0]                          r_m_resp  [axi_cfg_pkg::MST_NUM],
  output logic [axi_cfg_pkg::MST_NUM-1:0]     r_m_valid,
  input  logic [axi_cfg_pkg::MST_NUM-1:0]     r_m_ready
);

  axi_types_pkg::b_payload_t b_s_payload [axi_cfg_pkg::SLV_NUM];
  axi_types_pkg::b_payload_t b_m_payload [axi_cfg_pkg::MST_NUM];
  axi_types_pkg::r_payload_t r_s_payload [axi_cfg_pkg::SLV_NUM];
  axi_types_pkg::r_payload_t r_m_payload [axi_cfg_pkg::MST_NUM];

  // Slave fields into structs
  always_comb begin : pack_slaves
    for (int i = 0; i < axi_cfg_pkg::SLV_NUM; i++) begin
      b_s_payload[i].resp = b_s_resp[i];
      r_s_payload[i].data = r_s_data[i];
      r_s_payload[i].resp = r_s_resp[i];
    end
  end

  // Structs back out to master fields
  always_comb begin : unpack_masters
    for (int i = 0; i < axi_cfg_pkg::MST_NUM; i++) begin
      b_m_resp[i] = b_m_payload[i].resp;
      r_m_data[i] = r_m_payload[i].data;
      r_m_resp[i] = r_m_payload[i].resp;
    end
  end

  // Write response channel
  resp_arb #(
    .payload_t (axi_types_pkg::b_payload_t)
  ) u_b_arb (
    .clk       (clk),
    .rstn      (rstn),
    .s_id      (b_s_id),
    .s_payload (b_s_payload),
    .s_valid   (b_s_valid),
    .s_ready   (b_s_ready),
    .m_id      (b_m_id),
    .m_payload (b_m_payload),
    .m_valid   (b_m_valid),
    .m_ready   (b_m_ready)
  );

  // Read response channel
  resp_arb #(
    .payload_t (axi_types_pkg::r_payload_t)
  ) u_r_arb (
    .clk       (clk),
    .rstn      (rstn),
    .s_id      (r_s_id),
    .s_payload (r_s_payload),
    .s_valid   (r_s_valid),
    .s_ready   (r_s_ready),
    .m_id      (r_m_id),
    .m_payload (r_m_payload),
    .m_valid   (r_m_valid),
    .m_ready   (r_m_ready)
  );

endmodule

`default_nettype wire

// File: resp_xbar_checker.sv
`timescale 1ns/1ps
`default_nettype none

module resp_xbar_checker (
  input logic                            clk,
  input logic                            rstn,
  input logic [axi_cfg_pkg::SLV_NUM-1:0] s_valid,
  input logic [axi_cfg_pkg::SLV_NUM-1:0] s_ready,
  input logic [axi_cfg_pkg::ID_BITS-1:0] m_id [axi_cfg_pkg::MST_NUM],
  input logic [axi_cfg_pkg::MST_NUM-1:0] m_valid,
  input logic [axi_cfg_pkg::MST_NUM-1:0] m_ready
);

  // Only one slave served per cycle
  a_ready_onehot: assert property (
    @(posedge clk) disable iff (!rstn) $onehot0(s_ready)
  ) else $error("s_ready has more than one bit set: %b", s_ready);

  // Master valid always traces back to a slave
  a_valid_source: assert property (
    @(posedge clk) disable iff (!rstn) |m_valid |-> |s_valid
  ) else $error("m_valid %b raised with no slave valid", m_valid);

  for (genvar i = 0; i < axi_cfg_pkg::MST_NUM; i++) begin : g_hold
    // Stalled response stays put
    a_hold: assert property (
      @(posedge clk) disable iff (!rstn)
      m_valid[i] && !m_ready[i] |=> m_valid[i] && $stable(m_id[i])
    ) else $error("master %0d lost valid or ID while stalled", i);
  end

endmodule

`default_nettype wire

// File: resp_xbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

module resp_xbar_tb;

  localparam int          CLK_PERIOD     = 100;
  localparam int          CH_NUM         = 2;
  localparam int          N_RAND         = 20;
  localparam int          N_ROT          = 6;
  localparam int          MAX_GAP        = 4;
  localparam int          RESP_TOTAL     = CH_NUM * axi_cfg_pkg::SLV_NUM * (N_RAND + N_ROT);
  localparam int          TIMEOUT_CYCLES = RESP_TOTAL * MAX_GAP * 4;
  localparam logic [31:0] SEED           = 32'hf3fb_167f;

  typedef logic [axi_cfg_pkg::IDS_BITS-1:0] sid_t;
  typedef logic [axi_cfg_pkg::ID_BITS-1:0]  mid_t;

  // Slave-side response, shared by both channels
  typedef struct packed {
    sid_t                              id;
    logic [axi_cfg_pkg::DATA_BITS-1:0] data;
    logic [1:0]                        resp;
  } rsp_t;

  logic                                clk;
  logic                                rstn;
  logic [axi_cfg_pkg::IDS_BITS-1:0]    b_s_id    [axi_cfg_pkg::SLV_NUM];
  logic [1:0]                          b_s_resp  [axi_cfg_pkg::SLV_NUM];
  logic [axi_cfg_pkg::SLV_NUM-1:0]     b_s_valid;
  logic [axi_cfg_pkg::SLV_NUM-1:0]     b_s_ready;
  logic [axi_cfg_pkg::ID_BITS-1:0]     b_m_id    [axi_cfg_pkg::MST_NUM];
  logic [1:0]                          b_m_resp  [axi_cfg_pkg::MST_NUM];
  logic [axi_cfg_pkg::MST_NUM-1:0]     b_m_valid;
  logic [axi_cfg_pkg::MST_NUM-1:0]     b_m_ready;
  logic [axi_cfg_pkg::IDS_BITS-1:0]    r_s_id    [axi_cfg_pkg::SLV_NUM];
  logic [axi_cfg_pkg::DATA_BITS-1:0]   r_s_data  [axi_cfg_pkg::SLV_NUM];
  logic [1:0]                          r_s_resp  [axi_cfg_pkg::SLV_NUM];
  logic [axi_cfg_pkg::SLV_NUM-1:0]     r_s_valid;
  logic [axi_cfg_pkg::SLV_NUM-1:0]     r_s_ready;
  logic [axi_cfg_pkg::ID_BITS-1:0]     r_m_id    [axi_cfg_pkg::MST_NUM];
  logic [axi_cfg_pkg::DATA_BITS-1:0]   r_m_data  [axi_cfg_pkg::MST_NUM];
  logic [1:0]                          r_m_resp  [axi_cfg_pkg::MST_NUM];
  logic [axi_cfg_pkg::MST_NUM-1:0]     r_m_valid;
  logic [axi_cfg_pkg::MST_NUM-1:0]     r_m_ready;

  // Channel 0 is B, channel 1 is R
  rsp_t send_q [CH_NUM][axi_cfg_pkg::SLV_NUM][$];
  rsp_t exp_q  [CH_NUM][axi_cfg_pkg::SLV_NUM][$];
  int   seq_cnt [CH_NUM][axi_cfg_pkg::SLV_NUM];
  int   rot_prev [CH_NUM];
  bit   rot_phase;

  resp_xbar u_resp_xbar (.*);

  bind resp_arb resp_xbar_checker u_checker (
    .clk     (clk),
    .rstn    (rstn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_id    (m_id),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Master index and master-side ID for a slave-side ID, -1 when unmapped
  function automatic int expected_route(input sid_t id, output mid_t mid);
    int mst;
    mst = int'(id[axi_cfg_pkg::IDS_BITS-1 -: axi_cfg_pkg::MST_BITS]);
    mid = id[axi_cfg_pkg::ID_BITS-1:0];
    if (mst >= axi_cfg_pkg::MST_NUM) begin
      mst = -1;
    end
    return mst;
  endfunction

  task automatic check_index(input string name, input int got, input int want);
    if (got != want) begin
      abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want));
    end
  endtask

  task automatic check_id(input string name, input mid_t got, input mid_t want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_b(input string name, input axi_types_pkg::b_payload_t got,
                         input axi_types_pkg::b_payload_t want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_r(input string name, input axi_types_pkg::r_payload_t got,
                         input axi_types_pkg::r_payload_t want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic gen_items(input int ch, input int s, input int n, input bit mapped_only);
    rsp_t        it;
    mid_t        mid;
    int unsigned code;
    for (int k = 0; k < n; k++) begin
      if (mapped_only || ($urandom % 6) != 0) begin
        code = $urandom % axi_cfg_pkg::MST_NUM;
      end else begin
        code = axi_cfg_pkg::MST_NUM + ($urandom % 2);
      end
      // Source slave sits in the two high ID bits
      it.id = sid_t'((code << axi_cfg_pkg::ID_BITS) | (s << (axi_cfg_pkg::ID_BITS - 2)) |
                     (seq_cnt[ch][s] % 4));
      it.data = $urandom;
      if (ch == 0) begin
        it.data = '0;
      end
      it.resp = 2'($urandom % 4);
      seq_cnt[ch][s]++;
      send_q[ch][s].push_back(it);
      if (expected_route(it.id, mid) >= 0) begin
        exp_q[ch][s].push_back(it);
      end
    end
  endtask

  function automatic logic [axi_cfg_pkg::SLV_NUM-1:0] slave_accepts(input int ch);
    logic [axi_cfg_pkg::SLV_NUM-1:0] acc;
    if (ch == 0) begin
      acc = b_s_valid & b_s_ready;
    end else begin
      acc = r_s_valid & r_s_ready;
    end
    return acc;
  endfunction

  function automatic bit all_empty();
    bit empty;
    empty = 1'b1;
    for (int ch = 0; ch < CH_NUM; ch++) begin
      for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
        if (send_q[ch][s].size() != 0 || exp_q[ch][s].size() != 0) begin
          empty = 1'b0;
        end
      end
    end
    return empty;
  endfunction

  task automatic take_expected(input int ch, input int src, input string name,
                               output rsp_t e);
    if (src >= axi_cfg_pkg::SLV_NUM) begin
      abort_run($sformatf("%s names source slave %0d, which does not exist", name, src));
    end else if (exp_q[ch][src].size() == 0) begin
      abort_run($sformatf("%s delivered a response slave %0d never sent", name, src));
    end else begin
      e = exp_q[ch][src].pop_front();
    end
  endtask

  task automatic check_b_transfer(input int m);
    rsp_t                      e;
    mid_t                      mid;
    int                        mst;
    axi_types_pkg::b_payload_t got;
    axi_types_pkg::b_payload_t want;
    take_expected(0, int'(b_m_id[m][axi_cfg_pkg::ID_BITS-1 -: 2]),
                  $sformatf("b_m_id[%0d]", m), e);
    mst = expected_route(e.id, mid);
    got.resp = b_m_resp[m];
    want.resp = e.resp;
    check_index("b_m_valid index", m, mst);
    check_id($sformatf("b_m_id[%0d]", m), b_m_id[m], mid);
    check_b($sformatf("b_m_resp[%0d]", m), got, want);
  endtask

  task automatic check_r_transfer(input int m);
    rsp_t                      e;
    mid_t                      mid;
    int                        mst;
    axi_types_pkg::r_payload_t got;
    axi_types_pkg::r_payload_t want;
    take_expected(1, int'(r_m_id[m][axi_cfg_pkg::ID_BITS-1 -: 2]),
                  $sformatf("r_m_id[%0d]", m), e);
    mst = expected_route(e.id, mid);
    got.data = r_m_data[m];
    got.resp = r_m_resp[m];
    want.data = e.data;
    want.resp = e.resp;
    check_index("r_m_valid index", m, mst);
    check_id($sformatf("r_m_id[%0d]", m), r_m_id[m], mid);
    check_r($sformatf("r_m_data/resp[%0d]", m), got, want);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin : compare
    logic [axi_cfg_pkg::SLV_NUM-1:0] acc;
    logic [axi_cfg_pkg::MST_NUM-1:0] mv;
    mid_t                            mid;
    int                              want;
    if (rstn) begin
      for (int m = 0; m < axi_cfg_pkg::MST_NUM; m++) begin
        if (b_m_valid[m] && b_m_ready[m]) begin
          check_b_transfer(m);
        end
        if (r_m_valid[m] && r_m_ready[m]) begin
          check_r_transfer(m);
        end
      end
      for (int ch = 0; ch < CH_NUM; ch++) begin
        acc = slave_accepts(ch);
        mv = (ch == 0) ? b_m_valid : r_m_valid;
        for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
          // Dropped response must not show at any master
          if (acc[s] && expected_route(send_q[ch][s][0].id, mid) < 0) begin
            check_index((ch == 0) ? "b_m_valid" : "r_m_valid", int'(mv), 0);
          end
          if (acc[s] && rot_phase) begin
            want = (rot_prev[ch] < 0) ? 0 : (rot_prev[ch] + 1) % axi_cfg_pkg::SLV_NUM;
            check_index($sformatf("ch%0d serving slave", ch), s, want);
            rot_prev[ch] = s;
          end
        end
      end
    end
  end

  // Slave and master models for both channels
  initial begin : stimulus
    logic [axi_cfg_pkg::SLV_NUM-1:0] acc [CH_NUM];
    int                              gap [CH_NUM][axi_cfg_pkg::SLV_NUM];
    bit                              busy [CH_NUM][axi_cfg_pkg::SLV_NUM];
    rsp_t                            cur;
    gap = '{default: 0};
    busy = '{default: 0};
    wait (rstn === 1'b1);
    forever begin
      @(negedge clk);
      for (int ch = 0; ch < CH_NUM; ch++) begin
        acc[ch] = slave_accepts(ch);
      end
      @(posedge clk);
      #1;
      for (int ch = 0; ch < CH_NUM; ch++) begin
        for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
          if (acc[ch][s]) begin
            void'(send_q[ch][s].pop_front());
            busy[ch][s] = 1'b0;
            gap[ch][s] = rot_phase ? 0 : int'($urandom % (MAX_GAP + 1));
          end
          if (!busy[ch][s]) begin
            if (gap[ch][s] > 0) begin
              gap[ch][s]--;
            end else if (send_q[ch][s].size() > 0) begin
              busy[ch][s] = 1'b1;
            end
          end
        end
      end
      for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
        cur = '0;
        if (busy[0][s]) begin
          cur = send_q[0][s][0];
        end
        b_s_valid[s] = busy[0][s];
        b_s_id[s] = cur.id;
        b_s_resp[s] = cur.resp;
        cur = '0;
        if (busy[1][s]) begin
          cur = send_q[1][s][0];
        end
        r_s_valid[s] = busy[1][s];
        r_s_id[s] = cur.id;
        r_s_data[s] = cur.data;
        r_s_resp[s] = cur.resp;
      end
      for (int m = 0; m < axi_cfg_pkg::MST_NUM; m++) begin
        b_m_ready[m] = rot_phase || (($urandom % 4) != 0);
        r_m_ready[m] = rot_phase || (($urandom % 4) != 0);
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before all responses were delivered");
  end

  initial begin : main
    void'($urandom(SEED));
    clk = 1'b0;
    rstn = 1'b0;
    b_s_valid = '0;
    r_s_valid = '0;
    b_m_ready = '0;
    r_m_ready = '0;
    for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
      b_s_id[s] = '0;
      b_s_resp[s] = '0;
      r_s_id[s] = '0;
      r_s_data[s] = '0;
      r_s_resp[s] = '0;
    end
    seq_cnt = '{default: 0};
    rot_prev = '{default: -1};
    rot_phase = 1'b0;

    // Random gaps, random back-pressure, some unmapped codes
    for (int ch = 0; ch < CH_NUM; ch++) begin
      for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
        gen_items(ch, s, N_RAND, 1'b0);
      end
    end
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    while (!all_empty()) @(negedge clk);

    // All slaves busy at once, masters always ready
    repeat (MAX_GAP + 2) @(posedge clk);
    @(negedge clk);
    rot_phase = 1'b1;
    for (int ch = 0; ch < CH_NUM; ch++) begin
      for (int s = 0; s < axi_cfg_pkg::SLV_NUM; s++) begin
        gen_items(ch, s, N_ROT, 1'b1);
      end
    end
    while (!all_empty()) @(negedge clk);
    repeat (2) @(posedge clk);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
axi_cfg_pkg.sv
axi_types_pkg.sv
resp_arb.sv
resp_xbar.sv
resp_xbar_checker.sv
resp_xbar_tb.sv

// File: Makefile
# Verilator simulation of the response crossbar
VERILATOR ?= verilator
TOP       ?= resp_xbar_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
